// ==== Bender.yml ====
package:
  name: pc8001_kbd

sources:
  - include_dirs:
      - hw
    files:
      - hw/kbd_pkg.sv
      - hw/keymap_decode.sv
      - hw/key_event.sv
      - hw/kbd_port_read.sv
      - hw/kbd_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/tb_kbd_top.sv

// ==== hw/kbd_defines.svh ====
// PS/2 set 2 codes for left-hand modifiers only, and row F is reserved to mean no key held
`ifndef KBD_DEFINES_SVH
`define KBD_DEFINES_SVH

// ****************************************
// PS/2 scan codes
// ****************************************
`define KBD_CODE_BREAK  8'hF0   // break prefix
`define KBD_CODE_SHIFT  8'h12   // left shift
`define KBD_CODE_KANA   8'h13
`define KBD_CODE_CTRL   8'h14   // left ctrl
`define KBD_CODE_GRAPH  8'h11   // left alt stands in for graph

// matrix rows
`define KBD_ROW_NONE    4'hF    // nothing held
`define KBD_ROW_MOD     4'h8    // modifiers share the cursor row

// row 8 modifier bits
`define KBD_MASK_SHIFT  8'h40
`define KBD_MASK_KANA   8'h20
`define KBD_MASK_GRAPH  8'h10
`define KBD_MASK_CTRL   8'h80

`define KBD_RELEASE_READS 4'd14 // port 00h reads before the held key drops
`endif

// ==== hw/kbd_pkg.sv ====
// Widths follow the PC-8001 key matrix and break tracking only knows make and break
`default_nettype none

package kbd_pkg;

   // ****************************************
   // vector types
   // ****************************************

   // raw PS/2 set 2 code byte
   typedef logic [7:0] scan_code_t;

   // matrix row, also the row the cpu addresses
   typedef logic [3:0] row_addr_t;

   // one row of the key matrix, bit set = key down
   typedef logic [7:0] key_bits_t;

   // counts port 00h reads while a key is held
   typedef logic [3:0] read_cnt_t;

   // ****************************************
   // state machines
   // ****************************************

   // set by F0, cleared by the next code
   typedef enum logic {
      st_make,
      st_break
   } brk_state_t;

endpackage

`default_nettype wire

// ==== hw/kbd_port_read.sv ====
// cpu_addr is used without synchronizing and kb_data follows it one clock later
`default_nettype none
`include "kbd_defines.svh"

module kbd_port_read import kbd_pkg::*; (
   input  logic      I_CLK,
   input  logic      I_RST,
   input  row_addr_t cpu_addr,
   input  row_addr_t key_row,
   input  key_bits_t key_bits,
   input  logic      key_alt,
   input  logic      mod_shift,
   input  logic      mod_kana,
   input  logic      mod_ctrl,
   input  logic      mod_graph,
   output key_bits_t kb_data
);

   key_bits_t row_data;

   // ****************************************
   // row select, modifiers first on row 8
   // ****************************************
   always_comb begin
      row_data = (cpu_addr == key_row) ? key_bits : 8'h00;
      if (cpu_addr == `KBD_ROW_MOD) begin
         if (mod_shift) begin
            row_data = `KBD_MASK_SHIFT;
         end else if (key_alt) begin
            row_data = `KBD_MASK_SHIFT | key_bits;   // shifted cursor twin
         end else if (mod_kana) begin
            row_data = `KBD_MASK_KANA;
         end else if (mod_graph) begin
            row_data = `KBD_MASK_GRAPH;
         end else if (mod_ctrl) begin
            row_data = `KBD_MASK_CTRL;
         end
      end
   end

   // output retiming
   always_ff @(posedge I_CLK or posedge I_RST) begin
      if (I_RST) begin
         kb_data <= 8'h00;
      end else begin
         kb_data <= row_data;
      end
   end

endmodule

`default_nettype wire

// ==== hw/kbd_top.sv ====
// One scan code per single-cycle strobe with no back-pressure, and only one key is held at a time
`default_nettype none

module kbd_top import kbd_pkg::*; (
   input  logic       I_CLK,
   input  logic       I_RST,
   input  row_addr_t  cpu_addr,
   input  logic       cpu_iorq,
   input  logic       cpu_port00h,
   input  scan_code_t scan_code,
   input  logic       scan_valid,
   output key_bits_t  kb_data
);

   // decoder outputs
   logic      dec_hit;
   row_addr_t dec_row;
   key_bits_t dec_bits;
   logic      dec_alt;

   // held key and modifier levels
   row_addr_t key_row;
   key_bits_t key_bits;
   logic      key_alt;
   logic      mod_shift;
   logic      mod_kana;
   logic      mod_ctrl;
   logic      mod_graph;

   // ****************************************
   // scan code table
   // ****************************************
   keymap_decode i_keymap_decode (
      .scan_code (scan_code),
      .dec_hit   (dec_hit),
      .dec_row   (dec_row),
      .dec_bits  (dec_bits),
      .dec_alt   (dec_alt)
   );

   key_event i_key_event (
      .I_CLK       (I_CLK),
      .I_RST       (I_RST),
      .scan_valid  (scan_valid),
      .scan_code   (scan_code),
      .dec_hit     (dec_hit),
      .dec_row     (dec_row),
      .dec_bits    (dec_bits),
      .dec_alt     (dec_alt),
      .cpu_iorq    (cpu_iorq),
      .cpu_port00h (cpu_port00h),
      .key_row     (key_row),
      .key_bits    (key_bits),
      .key_alt     (key_alt),
      .mod_shift   (mod_shift),
      .mod_kana    (mod_kana),
      .mod_ctrl    (mod_ctrl),
      .mod_graph   (mod_graph)
   );

   // cpu side
   kbd_port_read i_kbd_port_read (
      .I_CLK     (I_CLK),
      .I_RST     (I_RST),
      .cpu_addr  (cpu_addr),
      .key_row   (key_row),
      .key_bits  (key_bits),
      .key_alt   (key_alt),
      .mod_shift (mod_shift),
      .mod_kana  (mod_kana),
      .mod_ctrl  (mod_ctrl),
      .mod_graph (mod_graph),
      .kb_data   (kb_data)
   );

endmodule

`default_nettype wire

// ==== hw/key_event.sv ====
// cpu_iorq is synchronized here but cpu_port00h is not, so it must be steady around the IORQ rise
`default_nettype none
`include "kbd_defines.svh"

module key_event import kbd_pkg::*; (
   input  logic       I_CLK,
   input  logic       I_RST,
   input  logic       scan_valid,
   input  scan_code_t scan_code,
   input  logic       dec_hit,
   input  row_addr_t  dec_row,
   input  key_bits_t  dec_bits,
   input  logic       dec_alt,
   input  logic       cpu_iorq,
   input  logic       cpu_port00h,
   output row_addr_t  key_row,
   output key_bits_t  key_bits,
   output logic       key_alt,
   output logic       mod_shift,
   output logic       mod_kana,
   output logic       mod_ctrl,
   output logic       mod_graph
);

   // ****************************************
   // IORQ synchronizer and rise detect
   // ****************************************
   logic [1:0] iorq_sync;
   logic       iorq_prev;
   logic       read_hit;   // one counted port 00h read

   always_ff @(posedge I_CLK or posedge I_RST) begin
      if (I_RST) begin
         iorq_sync <= 2'b00;
         iorq_prev <= 1'b0;
      end else begin
         iorq_sync <= {iorq_sync[0], cpu_iorq};
         iorq_prev <= iorq_sync[1];
      end
   end

   assign read_hit = iorq_sync[1] & ~iorq_prev & cpu_port00h;

   // ****************************************
   // break tracking and held key
   // ****************************************
   brk_state_t brk_state;
   read_cnt_t  read_cnt;
   logic       key_held;
   logic       is_mod;

   assign key_held = (key_row != `KBD_ROW_NONE);
   assign is_mod   = (scan_code == `KBD_CODE_SHIFT) || (scan_code == `KBD_CODE_KANA) ||
                     (scan_code == `KBD_CODE_CTRL)  || (scan_code == `KBD_CODE_GRAPH);

   always_ff @(posedge I_CLK or posedge I_RST) begin
      if (I_RST) begin
         brk_state <= st_make;
         key_row   <= `KBD_ROW_NONE;
         key_bits  <= 8'h00;
         key_alt   <= 1'b0;
         read_cnt  <= 4'd0;
         mod_shift <= 1'b0;
         mod_kana  <= 1'b0;
         mod_ctrl  <= 1'b0;
         mod_graph <= 1'b0;
      end else if (scan_valid) begin   // a scan beats a read in the same cycle
         if (scan_code == `KBD_CODE_BREAK) begin
            brk_state <= st_break;
         end else if (brk_state == st_break) begin
            brk_state <= st_make;   // key breaks are otherwise ignored
            case (scan_code)
               `KBD_CODE_SHIFT : mod_shift <= 1'b0;
               `KBD_CODE_KANA  : mod_kana  <= 1'b0;
               `KBD_CODE_CTRL  : mod_ctrl  <= 1'b0;
               `KBD_CODE_GRAPH : mod_graph <= 1'b0;
               default         : ;
            endcase
         end else if (is_mod) begin
            case (scan_code)
               `KBD_CODE_SHIFT : mod_shift <= 1'b1;
               `KBD_CODE_KANA  : mod_kana  <= 1'b1;
               `KBD_CODE_CTRL  : mod_ctrl  <= 1'b1;
               default         : mod_graph <= 1'b1;
            endcase
         end else if (!dec_hit) begin
            // unknown code drops the held key
            key_row  <= `KBD_ROW_NONE;
            key_bits <= 8'h00;
            key_alt  <= 1'b0;
            read_cnt <= 4'd0;
         end else begin
            key_row  <= dec_row;
            key_bits <= dec_bits;
            key_alt  <= dec_alt;
            read_cnt <= 4'd0;
         end
      end else if (read_hit && key_held) begin
         if (read_cnt == `KBD_RELEASE_READS - 4'd1) begin
            key_row  <= `KBD_ROW_NONE;   // cpu has scanned it often enough
            key_bits <= 8'h00;
            key_alt  <= 1'b0;
            read_cnt <= 4'd0;
         end else begin
            read_cnt <= read_cnt + 4'd1;
         end
      end
   end

   // the table only has rows 1 to 9
   a_row_legal : assert property (@(posedge I_CLK) disable iff (I_RST)
      (key_row == `KBD_ROW_NONE) || ((key_row >= 4'd1) && (key_row <= 4'd9)));

   a_bits_row : assert property (@(posedge I_CLK) disable iff (I_RST)
      (key_bits == 8'h00) == (key_row == `KBD_ROW_NONE));

endmodule

`default_nettype wire

// ==== hw/keymap_decode.sv ====
// Fixed set 2 table for rows 1 to 9; E0 prefixes are ignored so cursor keys decode by base code
`default_nettype none
`include "kbd_defines.svh"

module keymap_decode import kbd_pkg::*; (
   input  scan_code_t scan_code,
   output logic       dec_hit,
   output row_addr_t  dec_row,
   output key_bits_t  dec_bits,
   output logic       dec_alt
);

   logic [12:0] entry; // {alt, row, bits}

   always_comb begin
      entry = {1'b0, `KBD_ROW_NONE, 8'h00};
      case (scan_code)
         8'h5A : entry = {1'b0, 4'h1, 8'h80}; // enter
         // ****************************************
         // row 2
         8'h54 : entry = {1'b0, 4'h2, 8'h01}; // @
         8'h1C : entry = {1'b0, 4'h2, 8'h02}; // A
         8'h32 : entry = {1'b0, 4'h2, 8'h04};
         8'h21 : entry = {1'b0, 4'h2, 8'h08};
         8'h23 : entry = {1'b0, 4'h2, 8'h10};
         8'h24 : entry = {1'b0, 4'h2, 8'h20};
         8'h2B : entry = {1'b0, 4'h2, 8'h40};
         8'h34 : entry = {1'b0, 4'h2, 8'h80}; // G
         // row 3
         8'h33 : entry = {1'b0, 4'h3, 8'h01}; // H
         8'h43 : entry = {1'b0, 4'h3, 8'h02};
         8'h3B : entry = {1'b0, 4'h3, 8'h04};
         8'h42 : entry = {1'b0, 4'h3, 8'h08};
         8'h4B : entry = {1'b0, 4'h3, 8'h10};
         8'h3A : entry = {1'b0, 4'h3, 8'h20};
         8'h31 : entry = {1'b0, 4'h3, 8'h40};
         8'h44 : entry = {1'b0, 4'h3, 8'h80}; // O
         // row 4
         8'h4D : entry = {1'b0, 4'h4, 8'h01}; // P
         8'h15 : entry = {1'b0, 4'h4, 8'h02};
         8'h2D : entry = {1'b0, 4'h4, 8'h04};
         8'h1B : entry = {1'b0, 4'h4, 8'h08};
         8'h2C : entry = {1'b0, 4'h4, 8'h10};
         8'h3C : entry = {1'b0, 4'h4, 8'h20};
         8'h2A : entry = {1'b0, 4'h4, 8'h40};
         8'h1D : entry = {1'b0, 4'h4, 8'h80}; // W
         // row 5
         8'h22 : entry = {1'b0, 4'h5, 8'h01}; // X
         8'h35 : entry = {1'b0, 4'h5, 8'h02};
         8'h1A : entry = {1'b0, 4'h5, 8'h04};
         8'h5B : entry = {1'b0, 4'h5, 8'h08}; // [
         8'h6A : entry = {1'b0, 4'h5, 8'h10}; // yen
         8'h5D : entry = {1'b0, 4'h5, 8'h20}; // ]
         8'h55 : entry = {1'b0, 4'h5, 8'h40}; // ^ on the = key
         8'h4E : entry = {1'b0, 4'h5, 8'h80}; // -
         // row 6 digits
         8'h45 : entry = {1'b0, 4'h6, 8'h01};
         8'h16 : entry = {1'b0, 4'h6, 8'h02};
         8'h1E : entry = {1'b0, 4'h6, 8'h04};
         8'h26 : entry = {1'b0, 4'h6, 8'h08};
         8'h25 : entry = {1'b0, 4'h6, 8'h10};
         8'h2E : entry = {1'b0, 4'h6, 8'h20};
         8'h36 : entry = {1'b0, 4'h6, 8'h40};
         8'h3D : entry = {1'b0, 4'h6, 8'h80};
         // row 7
         8'h3E : entry = {1'b0, 4'h7, 8'h01}; // 8
         8'h46 : entry = {1'b0, 4'h7, 8'h02}; // 9
         8'h52 : entry = {1'b0, 4'h7, 8'h04}; // :
         8'h4C : entry = {1'b0, 4'h7, 8'h08}; // ;
         8'h41 : entry = {1'b0, 4'h7, 8'h10};
         8'h49 : entry = {1'b0, 4'h7, 8'h20};
         8'h4A : entry = {1'b0, 4'h7, 8'h40}; // /
         8'h51 : entry = {1'b0, 4'h7, 8'h80}; // underscore
         // ****************************************
         // row 8 cursor block, alt = shifted twin
         8'h6C : entry = {1'b0, 4'h8, 8'h01}; // home / clr
         8'h75 : entry = {1'b0, 4'h8, 8'h02}; // up
         8'h72 : entry = {1'b1, 4'h8, 8'h02}; // down
         8'h74 : entry = {1'b0, 4'h8, 8'h04}; // right
         8'h6B : entry = {1'b1, 4'h8, 8'h04}; // left
         8'h71 : entry = {1'b0, 4'h8, 8'h08}; // del
         8'h70 : entry = {1'b1, 4'h8, 8'h08}; // ins
         // row 9
         8'h77 : entry = {1'b0, 4'h9, 8'h01}; // stop on pause
         8'h05 : entry = {1'b0, 4'h9, 8'h02}; // f1
         8'h06 : entry = {1'b0, 4'h9, 8'h04};
         8'h04 : entry = {1'b0, 4'h9, 8'h08};
         8'h0C : entry = {1'b0, 4'h9, 8'h10};
         8'h03 : entry = {1'b0, 4'h9, 8'h20}; // f5
         8'h29 : entry = {1'b0, 4'h9, 8'h40}; // space
         8'h76 : entry = {1'b0, 4'h9, 8'h80}; // esc
         default : entry = {1'b0, `KBD_ROW_NONE, 8'h00};
      endcase
   end

   assign dec_alt  = entry[12];
   assign dec_row  = entry[11:8];
   assign dec_bits = entry[7:0];
   assign dec_hit  = (entry[11:8] != `KBD_ROW_NONE);

   // a mapped key owns exactly one matrix position
   always_comb begin
      a_hit_onehot : assert final (!dec_hit || $onehot(dec_bits));
   end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+hw
hw/kbd_pkg.sv
hw/keymap_decode.sv
hw/key_event.sv
hw/kbd_port_read.sv
hw/kbd_top.sv
tests/tb_kbd_top.sv

// ==== tests/tb_kbd_top.sv ====
// Random keys come from a fixed seed, and release timing is only checked on row 2
`default_nettype none
`include "kbd_defines.svh"

module tb_kbd_top import kbd_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   logic       I_CLK;
   logic       I_RST;
   row_addr_t  cpu_addr;
   logic       cpu_iorq;
   logic       cpu_port00h;
   scan_code_t scan_code;
   logic       scan_valid;
   key_bits_t  kb_data;

   int errors;
   int tests;

   scan_code_t key_code [1:9][0:7];  // reference matrix with 00 as an empty slot
   scan_code_t alt_code [0:7];       // shifted twins on row 8
   scan_code_t mapped [$];

   // reference state
   row_addr_t ref_row;
   key_bits_t ref_bits;
   logic      ref_alt;
   logic      ref_break;
   logic      ref_shift;
   logic      ref_kana;
   logic      ref_ctrl;
   logic      ref_graph;
   int        ref_cnt;

   always #5 I_CLK = ~I_CLK;

   kbd_top i_dut (
      .I_CLK       (I_CLK),
      .I_RST       (I_RST),
      .cpu_addr    (cpu_addr),
      .cpu_iorq    (cpu_iorq),
      .cpu_port00h (cpu_port00h),
      .scan_code   (scan_code),
      .scan_valid  (scan_valid),
      .kb_data     (kb_data)
   );

   // ****************************************
   // output checks
   // ****************************************
   a_known : assert property (@(posedge I_CLK) disable iff (I_RST) !$isunknown(kb_data))
      else begin
         $display("kb_data went unknown at %0t", $time);
         errors++;
      end

   // only row 8 can show more than one bit
   a_single_bit : assert property (@(posedge I_CLK) disable iff (I_RST)
      ($past(cpu_addr) != `KBD_ROW_MOD) |-> $onehot0(kb_data))
      else begin
         $display("more than one bit set outside row 8 at %0t", $time);
         errors++;
      end

   function automatic logic [12:0] lookup(input scan_code_t code);
      logic [12:0] hit;
      int          r;
      int          b;
      hit = {1'b0, `KBD_ROW_NONE, 8'h00};
      for (r = 1; r <= 9; r++) begin
         for (b = 0; b < 8; b++) begin
            if (code != 8'h00 && key_code[r][b] == code) begin
               hit = {1'b0, r[3:0], 8'h01 << b};
            end
            if (r == 8 && code != 8'h00 && alt_code[b] == code) begin
               hit = {1'b1, 4'h8, 8'h01 << b};
            end
         end
      end
      return hit;
   endfunction

   function automatic key_bits_t expected_data(input row_addr_t addr);
      key_bits_t val;
      val = (addr == ref_row) ? ref_bits : 8'h00;
      if (addr == `KBD_ROW_MOD) begin
         if (ref_shift) begin
            val = `KBD_MASK_SHIFT;
         end else if (ref_alt) begin
            val = `KBD_MASK_SHIFT | ref_bits;
         end else if (ref_kana) begin
            val = `KBD_MASK_KANA;
         end else if (ref_graph) begin
            val = `KBD_MASK_GRAPH;
         end else if (ref_ctrl) begin
            val = `KBD_MASK_CTRL;
         end
      end
      return val;
   endfunction

   // ****************************************
   // stimulus
   // ****************************************
   task automatic send_code(input scan_code_t code);
      logic [12:0] hit;
      @(negedge I_CLK);
      scan_code  = code;
      scan_valid = 1'b1;
      @(negedge I_CLK);
      scan_valid = 1'b0;
      hit = lookup(code);
      if (code == `KBD_CODE_BREAK) begin
         ref_break = 1'b1;
      end else if (ref_break) begin
         ref_break = 1'b0;   // key breaks leave the held key alone
         case (code)
            `KBD_CODE_SHIFT : ref_shift = 1'b0;
            `KBD_CODE_KANA  : ref_kana  = 1'b0;
            `KBD_CODE_CTRL  : ref_ctrl  = 1'b0;
            `KBD_CODE_GRAPH : ref_graph = 1'b0;
            default         : ;
         endcase
      end else begin
         case (code)
            `KBD_CODE_SHIFT : ref_shift = 1'b1;
            `KBD_CODE_KANA  : ref_kana  = 1'b1;
            `KBD_CODE_CTRL  : ref_ctrl  = 1'b1;
            `KBD_CODE_GRAPH : ref_graph = 1'b1;
            default : begin
               ref_row  = hit[11:8];   // unmapped gives row none
               ref_bits = hit[7:0];
               ref_alt  = hit[12];
               ref_cnt  = 0;
            end
         endcase
      end
   endtask

   task automatic cpu_read(input row_addr_t addr, input logic port00h);
      @(negedge I_CLK);
      cpu_addr    = addr;
      cpu_port00h = port00h;
      cpu_iorq    = 1'b1;
      repeat (4) @(negedge I_CLK);   // long enough for the synchronizer
      cpu_iorq = 1'b0;
      repeat (4) @(negedge I_CLK);
      cpu_port00h = 1'b0;
      if (port00h && ref_row != `KBD_ROW_NONE) begin
         ref_cnt++;
         if (ref_cnt == `KBD_RELEASE_READS) begin
            ref_row  = `KBD_ROW_NONE;
            ref_bits = 8'h00;
            ref_alt  = 1'b0;
            ref_cnt  = 0;
         end
      end
   endtask

   task automatic expect_row(input row_addr_t addr);
      key_bits_t want;
      @(negedge I_CLK);
      cpu_addr = addr;
      @(posedge I_CLK);
      @(posedge I_CLK);
      @(negedge I_CLK);
      want = expected_data(addr);
      a_row : assert (kb_data === want) else begin
         $display("ERR %0t kb_data row %h expected %02h got %02h", $time, addr, want, kb_data);
         errors++;
      end
   endtask

   task automatic wait_data(input key_bits_t want, input int limit);
      int n;
      n = 0;
      while (kb_data !== want && n < limit) begin
         @(negedge I_CLK);
         n++;
      end
      a_wait : assert (kb_data === want) else begin
         $display("timed out waiting for kb_data to become %02h", want);
         errors++;
      end
   endtask

   task automatic report_test(input string name, input int mark);
      tests++;
      if (errors == mark) begin
         $display("test %0d %s ok", tests, name);
      end else begin
         $display("test %0d %s had %0d errors", tests, name, errors - mark);
      end
   endtask

   // ****************************************
   // test sequence
   // ****************************************
   initial begin
      int          mark;
      scan_code_t  pick;
      row_addr_t   other;
      logic [12:0] hit;
      scan_code_t  mods [0:3];
      void'($urandom(32'h1732_9151));
      I_CLK = 1'b0;
      I_RST = 1'b1;
      cpu_addr = 4'h0;
      cpu_iorq = 1'b0;
      cpu_port00h = 1'b0;
      scan_code = 8'h00;
      scan_valid = 1'b0;
      errors = 0;
      tests = 0;
      ref_row = `KBD_ROW_NONE;
      ref_bits = 8'h00;
      ref_alt = 1'b0;
      ref_break = 1'b0;
      ref_shift = 1'b0;
      ref_kana = 1'b0;
      ref_ctrl = 1'b0;
      ref_graph = 1'b0;
      ref_cnt = 0;
      key_code[1] = '{8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h5A};
      key_code[2] = '{8'h54, 8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34};
      key_code[3] = '{8'h33, 8'h43, 8'h3B, 8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44};
      key_code[4] = '{8'h4D, 8'h15, 8'h2D, 8'h1B, 8'h2C, 8'h3C, 8'h2A, 8'h1D};
      key_code[5] = '{8'h22, 8'h35, 8'h1A, 8'h5B, 8'h6A, 8'h5D, 8'h55, 8'h4E};
      key_code[6] = '{8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D};
      key_code[7] = '{8'h3E, 8'h46, 8'h52, 8'h4C, 8'h41, 8'h49, 8'h4A, 8'h51};
      key_code[8] = '{8'h6C, 8'h75, 8'h74, 8'h71, 8'h00, 8'h00, 8'h00, 8'h00};
      key_code[9] = '{8'h77, 8'h05, 8'h06, 8'h04, 8'h0C, 8'h03, 8'h29, 8'h76};
      alt_code    = '{8'h00, 8'h72, 8'h6B, 8'h70, 8'h00, 8'h00, 8'h00, 8'h00};
      mods = '{`KBD_CODE_SHIFT, `KBD_CODE_KANA, `KBD_CODE_CTRL, `KBD_CODE_GRAPH};
      for (int r = 1; r <= 9; r++) begin
         for (int b = 0; b < 8; b++) begin
            if (key_code[r][b] != 8'h00) mapped.push_back(key_code[r][b]);
            if (r == 8 && alt_code[b] != 8'h00) mapped.push_back(alt_code[b]);
         end
      end
      repeat (10) @(negedge I_CLK);
      I_RST = 1'b0;

      mark = errors;
      for (int a = 0; a < 16; a++) expect_row(a[3:0]);
      report_test("reset", mark);

      mark = errors;
      for (int i = 0; i < 20; i++) begin
         pick = mapped[$urandom_range(mapped.size() - 1)];
         hit  = lookup(pick);
         other = hit[11:8] + 4'd5;
         if (other == `KBD_ROW_MOD) other = 4'hA;   // skip the modifier row
         send_code(pick);
         expect_row(hit[11:8]);
         expect_row(other);
      end
      send_code(8'h6B);   // left is always an alt key
      expect_row(`KBD_ROW_MOD);
      report_test("random_keys", mark);

      mark = errors;
      send_code(8'h0E);
      for (int i = 0; i < 4; i++) begin
         send_code(mods[i]);
         expect_row(`KBD_ROW_MOD);
         send_code(`KBD_CODE_BREAK);
         send_code(mods[i]);
         expect_row(`KBD_ROW_MOD);
      end
      send_code(`KBD_CODE_SHIFT);
      send_code(`KBD_CODE_KANA);
      expect_row(`KBD_ROW_MOD);   // shift outranks kana
      send_code(`KBD_CODE_BREAK);
      send_code(8'h1C);
      expect_row(`KBD_ROW_MOD);
      send_code(`KBD_CODE_BREAK);
      send_code(`KBD_CODE_SHIFT);
      expect_row(`KBD_ROW_MOD);
      send_code(`KBD_CODE_BREAK);
      send_code(`KBD_CODE_KANA);
      expect_row(`KBD_ROW_MOD);
      report_test("modifiers", mark);

      mark = errors;
      send_code(8'h1C);
      for (int i = 0; i < 3; i++) cpu_read(4'h2, 1'b0);   // other ports
      for (int i = 0; i < 13; i++) cpu_read(4'h2, 1'b1);
      expect_row(4'h2);
      cpu_read(4'h2, 1'b1);
      wait_data(8'h00, 20);
      expect_row(4'h2);
      report_test("release", mark);

      mark = errors;
      send_code(8'h1C);
      expect_row(4'h2);
      send_code(8'h0E);   // unmapped
      expect_row(4'h2);
      send_code(8'h1C);
      send_code(`KBD_CODE_BREAK);
      send_code(8'h1C);
      expect_row(4'h2);
      report_test("unmapped_break", mark);

      $display("%0d tests run, %0d errors", tests, errors);
      if (errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
